/* hdl/procPkg.sv */
/*
 * Processor package.
 * Widths, opcodes, ALU function codes, the instruction word with its two
 * decodings and the control struct passed from controller to datapath.
 */
package procPkg;

  localparam int dataW     = 16;  // Data and register width.
  localparam int regAddrW  = 4;   // Register index width.
  localparam int dataAddrW = 8;   // Data memory address width.
  localparam int progAddrW = 7;   // Program memory address width.

  typedef enum logic [3:0] {
    opNop = 4'd0, opLoad = 4'd1, opStore = 4'd2, opAdd = 4'd3, opSub = 4'd4,
    opAnd = 4'd5, opOr = 4'd6, opXor = 4'd7, opNot = 4'd8, opLdi = 4'd9,
    opHalt = 4'd15
  } opcodeT;  // Codes 10 to 14 run as no-ops.

  typedef enum logic [2:0] {
    aluPassA, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNotA, aluIncA
  } aluOpT;

  typedef struct packed {
    opcodeT              opcode;
    logic [regAddrW-1:0] rd;  // Destination.
    logic [regAddrW-1:0] ra;  // Source A.
    logic [regAddrW-1:0] rb;  // Source B.
  } regFmtT;

  typedef struct packed {
    opcodeT               opcode;
    logic [regAddrW-1:0]  regIdx;   // Register loaded or stored.
    logic [dataAddrW-1:0] addrImm;  // Data address or immediate.
  } memFmtT;

  typedef union packed {
    regFmtT regFmt;  // ALU instructions.
    memFmtT memFmt;  // Load, store and load-immediate.
  } instrT;

  typedef enum logic [1:0] {wbAlu, wbMem, wbImm} wbSelT;

  typedef struct packed {
    logic [dataAddrW-1:0] dAddr;   // Data memory address.
    logic                 dWr;     // Data memory write.
    wbSelT                wbSel;   // Writeback source.
    logic [regAddrW-1:0]  wAddr;   // Register write index.
    logic                 wWr;     // Register write.
    logic [regAddrW-1:0]  raAddr;  // Read port A index.
    logic [regAddrW-1:0]  rbAddr;  // Read port B index.
    aluOpT                aluOp;   // ALU function.
    logic [dataW-1:0]     imm;     // Zero-extended immediate.
  } ctrlT;

endpackage

/* hdl/registerFile.sv */
`timescale 1ns/1ps
/*
 * Register file.
 * Sixteen 16-bit registers, two combinational read ports and one
 * synchronous write port. Register 0 is also presented on its own output.
 */
module registerFile (
  input  logic                          clock,   // System clock.
  input  logic                          rst,     // Clears all registers.
  input  logic [procPkg::dataW-1:0]     wData,   // Write data.
  input  logic [procPkg::regAddrW-1:0]  wAddr,   // Write index.
  input  logic                          wWr,     // Write enable.
  input  logic [procPkg::regAddrW-1:0]  raAddr,  // Port A index.
  input  logic [procPkg::regAddrW-1:0]  rbAddr,  // Port B index.
  output logic [procPkg::dataW-1:0]     raData,  // Port A data.
  output logic [procPkg::dataW-1:0]     rbData,  // Port B data.
  output logic [procPkg::dataW-1:0]     regZero  // Contents of register 0.
);

  logic [procPkg::dataW-1:0] regs [2**procPkg::regAddrW];  // Register array.

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 2**procPkg::regAddrW; i++) begin
        regs[i] <= '0;  // Every register reads zero after reset.
      end
    end else if (wWr) begin
      regs[wAddr] <= wData;  // Lands at the end of the write cycle.
    end
  end

  assign raData  = regs[raAddr];  // Combinational read.
  assign rbData  = regs[rbAddr];
  assign regZero = regs[0];       // Result register.

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps
/*
 * ALU.
 * Eight combinational functions on two 16-bit operands.
 * Arithmetic wraps at the data width.
 */
module alu (
  input  logic [procPkg::dataW-1:0] a,   // Operand A.
  input  logic [procPkg::dataW-1:0] b,   // Operand B.
  input  procPkg::aluOpT            op,  // Function select.
  output logic [procPkg::dataW-1:0] y    // Result.
);

  always_comb begin
    case (op)
      procPkg::aluPassA: y = a;
      procPkg::aluAdd:   y = a + b;   // Carry out is dropped.
      procPkg::aluSub:   y = a - b;   // A minus B.
      procPkg::aluAnd:   y = a & b;
      procPkg::aluOr:    y = a | b;
      procPkg::aluXor:   y = a ^ b;
      procPkg::aluNotA:  y = ~a;
      procPkg::aluIncA:  y = a + 1'b1;
      default:           y = a;
    endcase
  end

endmodule

/* hdl/dataRam.sv */
`timescale 1ns/1ps
/*
 * Data memory.
 * 256 by 16-bit words, synchronous write and registered read.
 * A write cycle returns the old contents of the address.
 */
module dataRam (
  input  logic                           clock,  // System clock.
  input  logic [procPkg::dataAddrW-1:0]  addr,   // Word address.
  input  logic [procPkg::dataW-1:0]      wData,  // Write data.
  input  logic                           wr,     // Write enable.
  output logic [procPkg::dataW-1:0]      rData   // Read data, one cycle late.
);

  logic [procPkg::dataW-1:0] mem [2**procPkg::dataAddrW];  // Storage.

  always_ff @(posedge clock) begin
    if (wr) begin
      mem[addr] <= wData;
    end
    rData <= mem[addr];  // Read before write.
  end

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps
/*
 * Datapath.
 * Register file feeding an ALU and a data memory side by side, with a
 * writeback selector that picks the ALU result, the memory word or the
 * immediate as the register write data.
 */
module datapath (
  input  logic                       clock,   // System clock.
  input  logic                       rst,     // Synchronous reset.
  input  procPkg::ctrlT              ctrl,    // Commands from the controller.
  output logic [procPkg::dataW-1:0]  regZero  // Register 0 contents.
);

  logic [procPkg::dataW-1:0] raData;  // Register port A.
  logic [procPkg::dataW-1:0] rbData;  // Register port B.
  logic [procPkg::dataW-1:0] aluY;    // ALU result.
  logic [procPkg::dataW-1:0] memQ;    // Data memory read word.
  logic [procPkg::dataW-1:0] wData;   // Register write data.

  registerFile uRegFile (
    .clock   (clock),
    .rst     (rst),
    .wData   (wData),
    .wAddr   (ctrl.wAddr),
    .wWr     (ctrl.wWr),
    .raAddr  (ctrl.raAddr),
    .rbAddr  (ctrl.rbAddr),
    .raData  (raData),
    .rbData  (rbData),
    .regZero (regZero)
  );

  alu uAlu (.a(raData), .b(rbData), .op(ctrl.aluOp), .y(aluY));

  dataRam uDataRam (
    .clock (clock),
    .addr  (ctrl.dAddr),
    .wData (raData),  // Stores take port A.
    .wr    (ctrl.dWr),
    .rData (memQ)
  );

  always_comb begin
    case (ctrl.wbSel)
      procPkg::wbMem: wData = memQ;      // Load writeback.
      procPkg::wbImm: wData = ctrl.imm;  // Load immediate.
      default:        wData = aluY;
    endcase
  end

endmodule

/* hdl/controller.sv */
`timescale 1ns/1ps
/*
 * Controller.
 * Program memory, program counter, instruction register and the
 * fetch/decode/execute FSM. Produces the datapath control struct
 * combinationally from the state and the instruction register.
 */
module controller (
  input  logic                          clock,     // System clock.
  input  logic                          rst,       // Synchronous reset.
  input  logic                          start,     // Run pulse.
  input  logic                          progWr,    // Program write enable.
  input  logic [procPkg::progAddrW-1:0] progAddr,  // Program write address.
  input  procPkg::instrT                progData,  // Program write word.
  output procPkg::ctrlT                 ctrl,      // Datapath commands.
  output logic                          done       // High while halted.
);

  typedef enum logic [2:0] {
    idle, fetch, decode, execute, writeBack, halted
  } stateT;

  procPkg::instrT progMem [2**procPkg::progAddrW];  // Program storage.
  procPkg::instrT progQ;                            // Word at pc, registered.
  procPkg::instrT ir;                               // Instruction register.
  logic [procPkg::progAddrW-1:0] pc;                // Program counter.
  stateT state;

  function automatic procPkg::aluOpT aluOpFor(procPkg::opcodeT op);
    case (op)
      procPkg::opAdd: return procPkg::aluAdd;
      procPkg::opSub: return procPkg::aluSub;
      procPkg::opAnd: return procPkg::aluAnd;
      procPkg::opOr:  return procPkg::aluOr;
      procPkg::opXor: return procPkg::aluXor;
      procPkg::opNot: return procPkg::aluNotA;
      default:        return procPkg::aluPassA;
    endcase
  endfunction

  always_ff @(posedge clock) begin
    if (progWr) begin
      progMem[progAddr] <= progData;  // Loader port.
    end
    progQ <= progMem[pc];  // Valid in decode.
  end

  always_ff @(posedge clock) begin
    if (state == decode) begin
      ir <= progQ;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= idle;
      pc    <= '0;
    end else begin
      case (state)
        idle, halted: begin
          if (start) begin
            pc    <= '0;  // Restart from the first word.
            state <= fetch;
          end
        end
        fetch: state <= decode;
        decode: begin
          pc <= pc + 1'b1;  // Wraps at the end of program memory.
          if (progQ.regFmt.opcode == procPkg::opHalt) begin
            state <= halted;
          end else begin
            state <= execute;
          end
        end
        execute: begin
          if (ir.memFmt.opcode == procPkg::opLoad) begin
            state <= writeBack;  // Wait for the registered read.
          end else begin
            state <= fetch;
          end
        end
        writeBack: state <= fetch;
        default: state <= idle;
      endcase
    end
  end

  always_comb begin
    ctrl = '0;  // No writes outside execute and writeback.
    if (state == execute) begin
      case (ir.regFmt.opcode)
        procPkg::opAdd, procPkg::opSub, procPkg::opAnd,
        procPkg::opOr, procPkg::opXor, procPkg::opNot: begin
          ctrl.raAddr = ir.regFmt.ra;
          ctrl.rbAddr = ir.regFmt.rb;
          ctrl.aluOp  = aluOpFor(ir.regFmt.opcode);
          ctrl.wbSel  = procPkg::wbAlu;
          ctrl.wAddr  = ir.regFmt.rd;
          ctrl.wWr    = 1'b1;
        end
        procPkg::opLdi: begin
          ctrl.imm   = {{(procPkg::dataW - procPkg::dataAddrW){1'b0}}, ir.memFmt.addrImm};
          ctrl.wbSel = procPkg::wbImm;
          ctrl.wAddr = ir.memFmt.regIdx;
          ctrl.wWr   = 1'b1;
        end
        procPkg::opStore: begin
          ctrl.raAddr = ir.memFmt.regIdx;  // Port A carries the store data.
          ctrl.dAddr  = ir.memFmt.addrImm;
          ctrl.dWr    = 1'b1;
        end
        procPkg::opLoad: ctrl.dAddr = ir.memFmt.addrImm;
        procPkg::opNop: ;
        default: ;  // Unknown codes do nothing.
      endcase
    end else if (state == writeBack) begin
      ctrl.dAddr = ir.memFmt.addrImm;
      ctrl.wbSel = procPkg::wbMem;
      ctrl.wAddr = ir.memFmt.regIdx;
      ctrl.wWr   = 1'b1;
    end
  end

  assign done = (state == halted);

endmodule

/* hdl/processor.sv */
`timescale 1ns/1ps
/*
 * Processor top level.
 * Joins the controller and the datapath. Programs are written through the
 * program port, start runs them and done marks the halt. Register 0 is
 * presented as the result.
 */
module processor (
  input  logic                          clock,     // System clock.
  input  logic                          rst,       // Synchronous reset.
  input  logic                          start,     // Run pulse.
  input  logic                          progWr,    // Program write enable.
  input  logic [procPkg::progAddrW-1:0] progAddr,  // Program write address.
  input  procPkg::instrT                progData,  // Program write word.
  output logic                          done,      // Program reached halt.
  output logic [procPkg::dataW-1:0]     regZero    // Register 0 contents.
);

  procPkg::ctrlT ctrl;  // Controller to datapath.

  controller uController (
    .clock    (clock),
    .rst      (rst),
    .start    (start),
    .progWr   (progWr),
    .progAddr (progAddr),
    .progData (progData),
    .ctrl     (ctrl),
    .done     (done)
  );

  datapath uDatapath (
    .clock   (clock),
    .rst     (rst),
    .ctrl    (ctrl),
    .regZero (regZero)
  );

endmodule

/* verification/processorTb.sv */
`timescale 1ns/1ps
/*
 * Processor testbench.
 * Loads programs through the program port, runs them and compares register 0
 * with a reference ISA model that keeps its own registers and data memory.
 */
module processorTb;

  localparam int waitLimit = 2000;  // Cycles allowed per wait.

  logic                          clock;
  logic                          rst;
  logic                          start;
  logic                          progWr;
  logic [procPkg::progAddrW-1:0] progAddr;
  procPkg::instrT                progData;
  logic                          done;
  logic [procPkg::dataW-1:0]     regZero;

  logic [15:0] prog [$];        // Program under test.
  logic [15:0] modelRegs [16];  // Reference registers, kept across runs.
  logic [15:0] modelMem [256];  // Reference data memory.
  bit          memValid [256];  // Addresses that hold a stored word.
  integer      seed = 32'h284d_322a;
  string       testName;        // Name of the pending compare.
  logic [15:0] expected;        // Model result of the pending compare.
  bit          armed;           // Set while a compare is pending.

  processor u_dut (
    .clock(clock), .rst(rst), .start(start), .progWr(progWr), .progAddr(progAddr),
    .progData(progData), .done(done), .regZero(regZero)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period.
  end

  task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [15:0] rnd(input logic [15:0] mask);
    return $random(seed) & mask;  // Masked random bits.
  endfunction

  function automatic logic [15:0] regInstr(input logic [3:0] op, rd, ra, rb);
    return {op, rd, ra, rb};
  endfunction

  function automatic logic [15:0] memInstr(input logic [3:0] op, r, input logic [7:0] a);
    return {op, r, a};
  endfunction

  // Executes prog on the model and returns register 0.
  function automatic logic [15:0] runModel();
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] ra;
    logic [3:0] rb;
    logic [7:0] a;
    bit         stop;
    stop = 1'b0;
    for (int pc = 0; pc < prog.size() && !stop; pc++) begin
      {op, rd, ra, rb} = prog[pc];
      a = {ra, rb};  // Address or immediate of the memory format.
      case (op)
        4'd1:  modelRegs[rd] = modelMem[a];
        4'd2:  modelMem[a] = modelRegs[rd];
        4'd3:  modelRegs[rd] = modelRegs[ra] + modelRegs[rb];
        4'd4:  modelRegs[rd] = modelRegs[ra] - modelRegs[rb];
        4'd5:  modelRegs[rd] = modelRegs[ra] & modelRegs[rb];
        4'd6:  modelRegs[rd] = modelRegs[ra] | modelRegs[rb];
        4'd7:  modelRegs[rd] = modelRegs[ra] ^ modelRegs[rb];
        4'd8:  modelRegs[rd] = ~modelRegs[ra];
        4'd9:  modelRegs[rd] = {8'h00, a};
        4'd15: stop = 1'b1;
        default: ;  // No-op.
      endcase
    end
    return modelRegs[0];
  endfunction

  task automatic waitDone();
    int n;
    n = 0;
    while (!done && n < waitLimit) begin
      @(negedge clock);
      n++;
    end
    if (!done) abortRun("Timed out waiting for done to rise");
  endtask

  task automatic waitCompare();
    int n;
    n = 0;
    while (armed && n < 10) begin
      @(negedge clock);
      n++;
    end
    if (armed) abortRun("Compare process never ran after done");
  endtask

  // Writes prog into program memory, pulses start and waits for the result.
  task automatic runProgram(input string name);
    expected = runModel();
    for (int i = 0; i < prog.size(); i++) begin
      progWr   = 1'b1;
      progAddr = i;
      progData = prog[i];
      @(negedge clock);
    end
    progWr = 1'b0;
    start  = 1'b1;
    @(negedge clock);
    start = 1'b0;
    checkValue({name, " done after start"}, 16'd0, {15'd0, done});  // Must drop.
    testName = name;
    armed    = 1'b1;
    waitDone();
    waitCompare();
  endtask

  task automatic makeRandomProgram(input int len);
    logic [7:0] a;
    prog.delete();
    for (int i = 0; i < len; i++) begin
      a = 8'h40 + rnd(16'h7);  // Small window so loads find stores.
      case (rnd(16'h3))
        0: prog.push_back(memInstr(procPkg::opLdi, rnd(16'h3), rnd(16'hff)));
        1: prog.push_back(regInstr(4'd3 + ($unsigned($random(seed)) % 6), rnd(16'h3),
                                   rnd(16'h3), rnd(16'h3)));
        2: begin
          prog.push_back(memInstr(procPkg::opStore, rnd(16'h3), a));
          memValid[a] = 1'b1;
        end
        default: begin
          if (memValid[a]) prog.push_back(memInstr(procPkg::opLoad, rnd(16'h3), a));
          else prog.push_back(memInstr(procPkg::opLdi, rnd(16'h3), rnd(16'hff)));
        end
      endcase
    end
    prog.push_back(memInstr(procPkg::opHalt, 4'd0, 8'd0));
  endtask

  // Compare process. Samples on the falling edge where outputs are stable.
  always @(negedge clock) begin
    if (armed && done) begin
      checkValue(testName, expected, regZero);
      armed = 1'b0;
    end
  end

  initial begin
    logic [7:0] addr;
    rst = 1'b1;
    start = 1'b0;
    progWr = 1'b0;
    progAddr = '0;
    progData = '0;
    armed = 1'b0;
    for (int i = 0; i < 16; i++) modelRegs[i] = '0;
    for (int i = 0; i < 256; i++) memValid[i] = 1'b0;
    repeat (4) @(negedge clock);  // Reset held for 4 cycles.
    rst = 1'b0;
    @(negedge clock);
    checkValue("reset done", 16'd0, {15'd0, done});
    checkValue("reset regZero", 16'd0, regZero);
    for (int op = 3; op <= 8; op++) begin
      prog = '{memInstr(procPkg::opLdi, 4'd1, rnd(16'hff)),
               memInstr(procPkg::opLdi, 4'd2, rnd(16'hff)),
               regInstr(op, 4'd0, 4'd1, 4'd2),
               memInstr(procPkg::opHalt, 4'd0, 8'd0)};
      runProgram($sformatf("alu opcode %0d", op));
    end
    addr = rnd(16'hff);  // Memory round trip.
    memValid[addr] = 1'b1;
    prog = '{memInstr(procPkg::opLdi, 4'd1, rnd(16'hff)),
             memInstr(procPkg::opLdi, 4'd2, rnd(16'hff)),
             regInstr(procPkg::opSub, 4'd3, 4'd1, 4'd2),
             memInstr(procPkg::opStore, 4'd3, addr),
             memInstr(procPkg::opLdi, 4'd3, 8'h00),
             memInstr(procPkg::opLdi, 4'd0, 8'hff),
             memInstr(procPkg::opLoad, 4'd0, addr),
             memInstr(procPkg::opHalt, 4'd0, 8'd0)};
    runProgram("memory round trip");
    for (int t = 0; t < 4; t++) begin
      makeRandomProgram(20);
      runProgram($sformatf("random chain %0d", t));
    end
    prog = '{memInstr(procPkg::opLdi, 4'd0, rnd(16'hff)),
             memInstr(procPkg::opLdi, 4'd1, rnd(16'hff))};
    for (int op = 10; op <= 14; op++) begin
      prog.push_back(memInstr(op, 4'd0, rnd(16'hff)));  // Field names register 0.
    end
    prog.push_back(regInstr(procPkg::opAdd, 4'd0, 4'd0, 4'd1));
    prog.push_back(memInstr(procPkg::opHalt, 4'd0, 8'd0));
    runProgram("unknown opcodes");
    prog = '{memInstr(procPkg::opLdi, 4'd0, 8'h5a),  // New program after a halt.
             regInstr(procPkg::opNot, 4'd0, 4'd0, 4'd0),
             memInstr(procPkg::opHalt, 4'd0, 8'd0)};
    runProgram("restart");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
hdl/procPkg.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/dataRam.sv
hdl/datapath.sv
hdl/controller.sv
hdl/processor.sv
verification/processorTb.sv

/* Bender.yml */
package:
  name: processor

sources:
  - hdl/procPkg.sv
  - hdl/registerFile.sv
  - hdl/alu.sv
  - hdl/dataRam.sv
  - hdl/datapath.sv
  - hdl/controller.sv
  - hdl/processor.sv
  - target: test
    files:
      - verification/processorTb.sv
